/* source/chip_pkg.sv */
`default_nettype none

package chip_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// timing and sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int CLKS_PER_BIT = 16;
	localparam int RESET_HOLD_CYCLES = 15;
	localparam int INST_ADDR_BITS = 6;
	localparam int MAIN_ADDR_BITS = 8;
	localparam int FIFO_DEPTH_BITS = 4; // sixteen entries per uart buffer.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction set
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [7:0] {
		OP_LDI = 8'h01,
		OP_ADDI = 8'h02,
		OP_LD = 8'h03,
		OP_ST = 8'h04,
		OP_OUT = 8'h05,
		OP_BNZ = 8'h06,
		OP_HALT = 8'h00 // erased memory reads as halt.
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		logic [7:0] unused;
		logic [15:0] operand; // sign extended by LDI and ADDI.
	} instr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [7:0] uart_byte_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} mem_write_t;

	typedef struct packed {
		uart_byte_t data;
		logic frame_error;
	} rx_entry_t;

	typedef struct packed {
		logic loader_reset;
		logic loaded;
		logic halted;
		logic tx_pending;
		logic tx_seen;
		logic lost;
		logic rx_pending;
		logic rx_seen;
	} debug_t;

endpackage

`default_nettype wire

/* source/sync_fifo.sv */
`default_nettype none

module sync_fifo import chip_pkg::*; #(
	parameter type payload_t = uart_byte_t,
	parameter int DEPTH_BITS = FIFO_DEPTH_BITS
) (
	input wire logic clk,
	input wire logic chip_reset,
	input wire payload_t push_data,
	input wire logic push_valid,
	output logic push_ready,
	output payload_t pop_data,
	output logic pop_valid,
	input wire logic pop_ready,
	output logic [DEPTH_BITS:0] count
);

	payload_t mem [2 ** DEPTH_BITS];
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic do_push;
	logic do_pop;

	assign push_ready = !count[DEPTH_BITS]; // the top bit is only set when full.
	assign pop_valid = (count != 0);
	assign pop_data = mem[rd_ptr];
	assign do_push = push_valid && push_ready;
	assign do_pop = pop_valid && pop_ready;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (chip_reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	a_count_bound: assert property (@(posedge clk) disable iff (chip_reset)
		count <= (2 ** DEPTH_BITS))
		else $error("fifo count above depth");

endmodule

`default_nettype wire

/* source/uart_receiver.sv */
`default_nettype none

module uart_receiver import chip_pkg::*; (
	input wire logic clk,
	input wire logic chip_reset,
	input wire logic rx,
	output rx_entry_t entry,
	output logic entry_valid,
	input wire logic entry_ready,
	output logic lost
);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [$clog2(CLKS_PER_BIT)-1:0] tick;
	logic [2:0] bit_idx;
	uart_byte_t shift;
	logic pending;

	// a byte is offered only when it framed cleanly and the buffer has room.
	assign entry_valid = pending && !entry.frame_error && entry_ready;

	always_ff @(posedge clk) begin
		if (chip_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_DATA && tick == CLKS_PER_BIT - 1)
			shift <= {rx_sync, shift[7:1]}; // lowest bit arrives first.
		if (state == S_STOP && tick == CLKS_PER_BIT - 1) begin
			entry.data <= shift;
			entry.frame_error <= !rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (chip_reset) begin
			state <= S_IDLE;
			tick <= '0;
			bit_idx <= '0;
			pending <= 1'b0;
			lost <= 1'b0;
		end else begin
			pending <= 1'b0;
			if (pending && (entry.frame_error || !entry_ready))
				lost <= 1'b1;
			case (state)
				S_IDLE: begin
					tick <= '0;
					if (rx_prev && !rx_sync)
						state <= S_START;
				end
				S_START: begin
					if (tick == CLKS_PER_BIT / 2 - 1) begin
						tick <= '0;
						bit_idx <= '0;
						state <= rx_sync ? S_IDLE : S_DATA; // a glitch is not a start bit.
					end else begin
						tick <= tick + 1'b1;
					end
				end
				S_DATA: begin
					if (tick == CLKS_PER_BIT - 1) begin
						tick <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= S_STOP;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				default: begin
					if (tick == CLKS_PER_BIT - 1) begin
						pending <= 1'b1;
						state <= S_IDLE;
					end else begin
						tick <= tick + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/uart_transmitter.sv */
`default_nettype none

module uart_transmitter import chip_pkg::*; (
	input wire logic clk,
	input wire logic chip_reset,
	input wire uart_byte_t byte_in,
	input wire logic byte_valid,
	output logic byte_ready,
	output logic tx
);

	logic busy;
	logic [8:0] shift; // data bits still to send, then the stop bit.
	logic [3:0] bit_idx;
	logic [$clog2(CLKS_PER_BIT)-1:0] tick;

	assign byte_ready = !busy;

	always_ff @(posedge clk) begin
		if (!busy && byte_valid)
			shift <= {1'b1, byte_in};
		else if (busy && tick == CLKS_PER_BIT - 1)
			shift <= {1'b1, shift[8:1]};
	end

	always_ff @(posedge clk) begin
		if (chip_reset) begin
			busy <= 1'b0;
			tx <= 1'b1;
			bit_idx <= '0;
			tick <= '0;
		end else if (!busy) begin
			if (byte_valid) begin
				busy <= 1'b1;
				tx <= 1'b0; // start bit.
				bit_idx <= '0;
				tick <= '0;
			end
		end else if (tick == CLKS_PER_BIT - 1) begin
			tick <= '0;
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;
			end else begin
				tx <= shift[0];
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			tick <= tick + 1'b1;
		end
	end

	a_idle_high: assert property (@(posedge clk) disable iff (chip_reset)
		!busy |-> tx)
		else $error("tx line low while idle");

endmodule

`default_nettype wire

/* source/word_memory.sv */
`default_nettype none

module word_memory import chip_pkg::*; #(
	parameter int ADDR_BITS = INST_ADDR_BITS
) (
	input wire logic clk,
	input wire logic chip_reset,
	input wire mem_write_t write_req,
	input wire logic write_valid,
	output logic write_ready,
	input wire logic [31:0] read_addr,
	input wire logic read_valid,
	output logic [31:0] read_data,
	output logic read_ready
);

	logic [31:0] mem [2 ** ADDR_BITS];

	always_ff @(posedge clk) begin
		if (chip_reset) begin
			write_ready <= 1'b0;
			read_ready <= 1'b0;
		end else begin
			write_ready <= 1'b1;
			read_ready <= read_valid; // response follows a request by one cycle.
		end
	end

	// upper address bits are ignored, so addresses wrap at the depth.
	always_ff @(posedge clk) begin
		if (write_valid && write_ready)
			mem[write_req.addr[ADDR_BITS-1:0]] <= write_req.data;
		if (read_valid)
			read_data <= mem[read_addr[ADDR_BITS-1:0]];
	end

endmodule

`default_nettype wire

/* source/program_loader.sv */
`default_nettype none

module program_loader import chip_pkg::*; (
	input wire logic clk,
	input wire logic chip_reset,
	input wire uart_byte_t rx_byte,
	input wire logic rx_valid,
	output logic rx_ready,
	output mem_write_t write_req,
	output logic write_valid,
	input wire logic write_ready,
	output logic loaded
);

	typedef enum logic [1:0] {S_COUNT, S_BYTES, S_WRITE, S_DONE} state_t;

	state_t state;
	logic [INST_ADDR_BITS-1:0] word_idx;
	logic [INST_ADDR_BITS-1:0] word_last;
	logic [1:0] byte_idx;
	logic [31:0] word;

	assign rx_ready = (state == S_COUNT) || (state == S_BYTES);
	assign write_valid = (state == S_WRITE);
	assign loaded = (state == S_DONE);

	always_comb begin
		write_req.addr = 32'(word_idx);
		write_req.data = word;
	end

	always_ff @(posedge clk) begin
		if (state == S_BYTES && rx_valid)
			word <= {rx_byte, word[31:8]}; // little endian, low byte first.
	end

	always_ff @(posedge clk) begin
		if (chip_reset) begin
			state <= S_COUNT;
			word_idx <= '0;
			word_last <= '0;
			byte_idx <= '0;
		end else begin
			case (state)
				S_COUNT: begin
					if (rx_valid) begin
						word_last <= rx_byte[INST_ADDR_BITS-1:0] - 1'b1; // 64 wraps to 63.
						word_idx <= '0;
						byte_idx <= '0;
						state <= S_BYTES;
					end
				end
				S_BYTES: begin
					if (rx_valid) begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == 2'd3)
							state <= S_WRITE;
					end
				end
				S_WRITE: begin
					if (write_ready) begin
						if (word_idx == word_last) begin
							state <= S_DONE;
						end else begin
							word_idx <= word_idx + 1'b1;
							state <= S_BYTES;
						end
					end
				end
				default: state <= S_DONE;
			endcase
		end
	end

	a_no_write_after_load: assert property (@(posedge clk) disable iff (chip_reset)
		loaded |=> loaded && !write_valid)
		else $error("instruction write after load completed");

endmodule

`default_nettype wire

/* source/accumulator_core.sv */
`default_nettype none

module accumulator_core import chip_pkg::*; (
	input wire logic clk,
	input wire logic chip_reset,
	output logic [31:0] inst_addr,
	output logic inst_valid,
	input wire logic [31:0] inst_data,
	input wire logic inst_ready,
	output mem_write_t main_write,
	output logic main_write_valid,
	input wire logic main_write_ready,
	output logic [31:0] main_addr,
	output logic main_read_valid,
	input wire logic [31:0] main_data,
	input wire logic main_ready,
	output uart_byte_t tx_byte,
	output logic tx_valid,
	input wire logic tx_ready,
	output logic halted
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_FETCH_WAIT,
		S_EXEC,
		S_LOAD_WAIT,
		S_HALT
	} state_t;

	state_t state;
	instr_t ir;
	logic [INST_ADDR_BITS-1:0] pc;
	logic [INST_ADDR_BITS-1:0] pc_inc;
	logic [31:0] acc;
	logic [31:0] imm;
	logic in_exec;

	assign pc_inc = pc + 1'b1; // wraps at the instruction memory depth.
	assign imm = {{16{ir.operand[15]}}, ir.operand};
	assign in_exec = (state == S_EXEC);

	always_comb begin
		inst_valid = (state == S_FETCH);
		inst_addr = 32'(pc);
		main_addr = 32'(ir.operand);
		main_read_valid = in_exec && (ir.opcode == OP_LD);
		main_write.addr = 32'(ir.operand);
		main_write.data = acc;
		main_write_valid = in_exec && (ir.opcode == OP_ST);
		tx_byte = acc[7:0];
		tx_valid = in_exec && (ir.opcode == OP_OUT);
		halted = (state == S_HALT);
	end

	always_ff @(posedge clk) begin
		if (state == S_FETCH_WAIT && inst_ready)
			ir <= instr_t'(inst_data);
	end

	always_ff @(posedge clk) begin
		if (chip_reset) begin
			state <= S_IDLE;
			pc <= '0;
			acc <= '0;
		end else begin
			case (state)
				S_IDLE: state <= S_FETCH;
				S_FETCH: state <= S_FETCH_WAIT;
				S_FETCH_WAIT: begin
					if (inst_ready)
						state <= S_EXEC;
				end
				S_EXEC: begin
					case (ir.opcode)
						OP_LDI: begin
							acc <= imm;
							pc <= pc_inc;
							state <= S_FETCH;
						end
						OP_ADDI: begin
							acc <= acc + imm;
							pc <= pc_inc;
							state <= S_FETCH;
						end
						OP_LD: state <= S_LOAD_WAIT; // request is taken this cycle.
						OP_ST: begin
							if (main_write_ready) begin
								pc <= pc_inc;
								state <= S_FETCH;
							end
						end
						OP_OUT: begin
							if (tx_ready) begin
								pc <= pc_inc;
								state <= S_FETCH;
							end
						end
						OP_BNZ: begin
							pc <= (acc != 0) ? ir.operand[INST_ADDR_BITS-1:0] : pc_inc;
							state <= S_FETCH;
						end
						default: state <= S_HALT;
					endcase
				end
				S_LOAD_WAIT: begin
					if (main_ready) begin
						acc <= main_data;
						pc <= pc_inc;
						state <= S_FETCH;
					end
				end
				default: state <= S_HALT;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/chip.sv */
`default_nettype none

module chip import chip_pkg::*; (
	input wire logic clk,
	input wire logic chip_reset,
	input wire logic uart_rx,
	output logic uart_tx,
	output debug_t debug
);

	logic [4:0] reset_count;
	logic loader_reset;
	logic core_reset;
	logic rx_lost;
	logic rx_seen;
	logic tx_seen;

	rx_entry_t rx_entry;
	logic rx_entry_valid;
	logic rx_entry_ready;
	rx_entry_t rx_pop_entry;
	logic rx_pop_valid;
	logic rx_pop_ready;
	logic [FIFO_DEPTH_BITS:0] rx_count;

	uart_byte_t core_tx_byte;
	logic core_tx_valid;
	logic tx_push_valid;
	logic tx_push_ready;
	uart_byte_t tx_pop_byte;
	logic tx_pop_valid;
	logic tx_pop_ready;
	logic [FIFO_DEPTH_BITS:0] tx_count;

	mem_write_t inst_write;
	logic inst_write_valid;
	logic inst_write_ready;
	logic loaded;
	logic [31:0] inst_addr;
	logic inst_read_valid;
	logic [31:0] inst_data;
	logic inst_ready;

	mem_write_t main_write;
	logic main_write_valid;
	logic main_write_ready;
	logic [31:0] main_addr;
	logic main_read_valid;
	logic [31:0] main_data;
	logic main_ready;
	logic halted;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reset sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (chip_reset)
			reset_count <= 5'(RESET_HOLD_CYCLES);
		else if (reset_count != 0)
			reset_count <= reset_count - 1'b1;
	end

	always_comb begin
		loader_reset = chip_reset || (reset_count != 0);
		core_reset = !loaded; // the core waits for a complete program.
		tx_push_valid = core_tx_valid && loaded;
	end

	always_ff @(posedge clk) begin
		if (loader_reset) begin
			rx_seen <= 1'b0;
			tx_seen <= 1'b0;
		end else begin
			if (rx_count != 0)
				rx_seen <= 1'b1;
			if (tx_count != 0)
				tx_seen <= 1'b1;
		end
	end

	always_comb begin
		debug.loader_reset = loader_reset;
		debug.loaded = loaded;
		debug.halted = halted;
		debug.tx_pending = (tx_count != 0);
		debug.tx_seen = tx_seen;
		debug.lost = rx_lost;
		debug.rx_pending = (rx_count != 0);
		debug.rx_seen = rx_seen;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// uart side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	uart_receiver u_receiver (
		.clk(clk),
		.chip_reset(loader_reset),
		.rx(uart_rx),
		.entry(rx_entry),
		.entry_valid(rx_entry_valid),
		.entry_ready(rx_entry_ready),
		.lost(rx_lost)
	);

	sync_fifo #(.payload_t(rx_entry_t), .DEPTH_BITS(FIFO_DEPTH_BITS)) u_rx_fifo (
		.clk(clk),
		.chip_reset(loader_reset),
		.push_data(rx_entry),
		.push_valid(rx_entry_valid),
		.push_ready(rx_entry_ready),
		.pop_data(rx_pop_entry),
		.pop_valid(rx_pop_valid),
		.pop_ready(rx_pop_ready),
		.count(rx_count)
	);

	sync_fifo #(.payload_t(uart_byte_t), .DEPTH_BITS(FIFO_DEPTH_BITS)) u_tx_fifo (
		.clk(clk),
		.chip_reset(loader_reset),
		.push_data(core_tx_byte),
		.push_valid(tx_push_valid),
		.push_ready(tx_push_ready),
		.pop_data(tx_pop_byte),
		.pop_valid(tx_pop_valid),
		.pop_ready(tx_pop_ready),
		.count(tx_count)
	);

	uart_transmitter u_transmitter (
		.clk(clk),
		.chip_reset(loader_reset),
		.byte_in(tx_pop_byte),
		.byte_valid(tx_pop_valid),
		.byte_ready(tx_pop_ready),
		.tx(uart_tx)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// loader, core and memories
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	program_loader u_loader (
		.clk(clk),
		.chip_reset(loader_reset),
		.rx_byte(rx_pop_entry.data),
		.rx_valid(rx_pop_valid),
		.rx_ready(rx_pop_ready),
		.write_req(inst_write),
		.write_valid(inst_write_valid),
		.write_ready(inst_write_ready),
		.loaded(loaded)
	);

	word_memory #(.ADDR_BITS(INST_ADDR_BITS)) u_inst_mem (
		.clk(clk),
		.chip_reset(loader_reset),
		.write_req(inst_write),
		.write_valid(inst_write_valid),
		.write_ready(inst_write_ready),
		.read_addr(inst_addr),
		.read_valid(inst_read_valid),
		.read_data(inst_data),
		.read_ready(inst_ready)
	);

	word_memory #(.ADDR_BITS(MAIN_ADDR_BITS)) u_main_mem (
		.clk(clk),
		.chip_reset(core_reset),
		.write_req(main_write),
		.write_valid(main_write_valid),
		.write_ready(main_write_ready),
		.read_addr(main_addr),
		.read_valid(main_read_valid),
		.read_data(main_data),
		.read_ready(main_ready)
	);

	accumulator_core u_core (
		.clk(clk),
		.chip_reset(core_reset),
		.inst_addr(inst_addr),
		.inst_valid(inst_read_valid),
		.inst_data(inst_data),
		.inst_ready(inst_ready),
		.main_write(main_write),
		.main_write_valid(main_write_valid),
		.main_write_ready(main_write_ready),
		.main_addr(main_addr),
		.main_read_valid(main_read_valid),
		.main_data(main_data),
		.main_ready(main_ready),
		.tx_byte(core_tx_byte),
		.tx_valid(core_tx_valid),
		.tx_ready(tx_push_ready),
		.halted(halted)
	);

	// bad frames are filtered in the receiver, so none reach the loader.
	a_no_bad_frame: assert property (@(posedge clk) disable iff (loader_reset)
		rx_pop_valid |-> !rx_pop_entry.frame_error)
		else $error("framing error stored in receive buffer");

endmodule

`default_nettype wire

/* verification/chip_tb.sv */
`default_nettype none

module chip_tb import chip_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int WORDS_STRAIGHT = 10;
	localparam int WORDS_COUNTDOWN = 9;
	localparam int WORDS_FRAMING = 5;
	localparam int WORDS_BACKPRESSURE = 62;
	localparam int WORDS_RANDOM = 16;
	localparam int TOTAL_WORDS = WORDS_STRAIGHT + WORDS_COUNTDOWN + WORDS_FRAMING
		+ WORDS_BACKPRESSURE + WORDS_RANDOM;
	// count bytes, one bad frame, four bytes per word in and at most one byte per word out.
	localparam int FRAME_BOUND = 5 + 1 + 5 * TOTAL_WORDS;
	localparam int WATCHDOG_NS = FRAME_BOUND * 12 * CLKS_PER_BIT * CLK_PERIOD
		+ 20000 * CLK_PERIOD;

	logic clk;
	logic chip_reset;
	logic uart_rx;
	logic uart_tx;
	debug_t debug;

	logic [31:0] prog [64];
	int prog_len;
	logic [31:0] rng_state;
	uart_byte_t rx_q [$];
	uart_byte_t expected_q [$];
	event byte_seen;
	string test_name;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	chip u_chip (
		.clk(clk),
		.chip_reset(chip_reset),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.debug(debug)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model and program builders
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int ref_run(input int words);
		logic [31:0] acc;
		logic [31:0] data_mem [256];
		logic [5:0] pc;
		logic [31:0] word;
		logic [31:0] imm;
		int steps;
		bit running;
		acc = '0;
		pc = '0;
		steps = 0;
		running = 1'b1;
		while (running && steps < 4096) begin
			word = (pc < words) ? prog[pc] : 32'h0;
			imm = {{16{word[15]}}, word[15:0]}; // operands are sign extended.
			steps++;
			case (word[31:24])
				OP_LDI: begin
					acc = imm;
					pc = pc + 1'b1;
				end
				OP_ADDI: begin
					acc = acc + imm;
					pc = pc + 1'b1;
				end
				OP_LD: begin
					acc = data_mem[word[7:0]];
					pc = pc + 1'b1;
				end
				OP_ST: begin
					data_mem[word[7:0]] = acc;
					pc = pc + 1'b1;
				end
				OP_OUT: begin
					expected_q.push_back(acc[7:0]);
					pc = pc + 1'b1;
				end
				OP_BNZ: pc = (acc != 0) ? word[5:0] : pc + 1'b1;
				default: running = 1'b0;
			endcase
		end
		return expected_q.size();
	endfunction

	function automatic void emit(input opcode_t op, input logic [15:0] operand);
		prog[prog_len] = {op, 8'h00, operand};
		prog_len++;
	endfunction

	task automatic build_straight_line();
		prog_len = 0;
		emit(OP_LDI, 16'h0012);
		emit(OP_OUT, 16'h0000);
		emit(OP_ADDI, 16'h0021);
		emit(OP_OUT, 16'h0000);
		emit(OP_ADDI, 16'hffff);
		emit(OP_OUT, 16'h0000);
		emit(OP_LDI, 16'h007f);
		emit(OP_ADDI, 16'h0080);
		emit(OP_OUT, 16'h0000);
		emit(OP_HALT, 16'h0000);
	endtask

	task automatic build_countdown();
		prog_len = 0;
		emit(OP_LDI, 16'h0005);
		emit(OP_ST, 16'h0010);
		emit(OP_LD, 16'h0010); // loop head at word 2.
		emit(OP_OUT, 16'h0000);
		emit(OP_ADDI, 16'hffff);
		emit(OP_ST, 16'h0010);
		emit(OP_LD, 16'h0010);
		emit(OP_BNZ, 16'h0002);
		emit(OP_HALT, 16'h0000);
	endtask

	task automatic build_short_program();
		prog_len = 0;
		emit(OP_LDI, 16'h003c);
		emit(OP_OUT, 16'h0000);
		emit(OP_ADDI, 16'h0001);
		emit(OP_OUT, 16'h0000);
		emit(OP_HALT, 16'h0000);
	endtask

	task automatic build_burst();
		int i;
		prog_len = 0;
		emit(OP_LDI, 16'h0041);
		for (i = 0; i < 20; i++) begin
			emit(OP_OUT, 16'h0000);
			emit(OP_OUT, 16'h0000);
			emit(OP_ADDI, 16'h0001);
		end
		emit(OP_HALT, 16'h0000);
	endtask

	task automatic build_random_program();
		logic [31:0] r;
		int i;
		prog_len = 0;
		for (i = 0; i < WORDS_RANDOM - 1; i++) begin
			rng_state = xorshift32(rng_state);
			r = rng_state;
			case (r[1:0])
				2'd0: emit(OP_LDI, r[23:8]);
				2'd1: emit(OP_ADDI, r[23:8]);
				default: emit(OP_OUT, 16'h0000);
			endcase
		end
		emit(OP_HALT, 16'h0000);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks and bookkeeping
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic check_byte(input string what, input uart_byte_t expected,
		input uart_byte_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %02h, actual %02h", test_name, what,
				expected, actual);
			note_error();
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %0b, actual %0b", test_name, what,
				expected, actual);
			note_error();
		end
	endtask

	task automatic check_cycles(input string what, input int expected, input int actual);
		if (actual != expected) begin
			$display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what,
				expected, actual);
			note_error();
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, test_errors);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// serial driver and monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic send_frame(input uart_byte_t data, input logic stop_bit);
		int i;
		@(negedge clk);
		uart_rx = 1'b0;
		for (i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			uart_rx = data[i];
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		uart_rx = stop_bit;
		repeat (CLKS_PER_BIT) @(negedge clk);
		uart_rx = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge clk); // one idle bit between frames.
	endtask

	initial begin : serial_monitor
		uart_byte_t data;
		int i;
		forever begin
			@(negedge clk);
			if (chip_reset === 1'b0 && uart_tx === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				for (i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					data[i] = uart_tx;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (uart_tx !== 1'b1) begin
					$display("[FAIL] %s: a frame on uart_tx ended with a low stop bit",
						test_name);
					note_error();
				end
				rx_q.push_back(data);
				->byte_seen;
			end
		end
	end

	initial begin : compare_output
		uart_byte_t got;
		forever begin
			@(byte_seen);
			while (rx_q.size() != 0) begin
				got = rx_q.pop_front();
				if (expected_q.size() == 0) begin
					$display("%s: uart_tx sent byte %02h when no byte was expected",
						test_name, got);
					note_error();
				end else begin
					check_byte("uart_tx byte", expected_q.pop_front(), got);
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apply_reset();
		@(negedge clk);
		chip_reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		chip_reset = 1'b0;
	endtask

	task automatic load_and_run(input bit bad_frame);
		int i;
		int b;
		int n_out;
		int hold;
		expected_q.delete();
		n_out = ref_run(prog_len);
		apply_reset();
		hold = 0;
		while (debug.loader_reset !== 1'b0) begin
			hold++;
			@(negedge clk);
		end
		check_cycles("loader_reset hold", RESET_HOLD_CYCLES, hold);
		check_flag("loaded after reset", 1'b0, debug.loaded);
		check_flag("halted after reset", 1'b0, debug.halted);
		check_flag("lost after reset", 1'b0, debug.lost);
		check_flag("uart_tx after reset", 1'b1, uart_tx);
		check_flag("tx_pending after reset", 1'b0, debug.tx_pending);
		check_flag("tx_seen after reset", 1'b0, debug.tx_seen);
		check_flag("rx_pending after reset", 1'b0, debug.rx_pending);
		check_flag("rx_seen after reset", 1'b0, debug.rx_seen);
		if (bad_frame)
			send_frame(8'h5a, 1'b0);
		send_frame(uart_byte_t'(prog_len), 1'b1);
		for (i = 0; i < prog_len; i++) begin
			for (b = 0; b < 4; b++)
				send_frame(prog[i][8*b +: 8], 1'b1); // low byte first.
		end
		while (debug.halted !== 1'b1)
			@(negedge clk);
		while (debug.tx_pending !== 1'b0)
			@(negedge clk);
		repeat (11 * CLKS_PER_BIT) @(negedge clk); // last frame leaves the line.
		check_flag("rx_seen after load", 1'b1, debug.rx_seen);
		check_flag("rx_pending after load", 1'b0, debug.rx_pending);
		check_flag("tx_seen after run", n_out != 0, debug.tx_seen);
		if (expected_q.size() != 0) begin
			$display("%s: %0d expected bytes never arrived on uart_tx", test_name,
				expected_q.size());
			note_error();
		end
	endtask

	initial begin : main_sequence
		bit idle_low;
		chip_reset = 1'b1;
		uart_rx = 1'b1;
		rng_state = 32'h3742_9d6e;
		prog_len = 0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_name = "startup";

		begin_test("straight_line");
		build_straight_line();
		load_and_run(1'b0);
		end_test();

		begin_test("countdown_loop");
		build_countdown();
		load_and_run(1'b0);
		end_test();

		begin_test("halt_state");
		check_flag("halted", 1'b1, debug.halted);
		check_flag("loaded", 1'b1, debug.loaded);
		idle_low = 1'b0;
		repeat (2 * CLKS_PER_BIT) begin
			@(negedge clk);
			if (uart_tx !== 1'b1)
				idle_low = 1'b1;
		end
		check_flag("uart_tx idle", 1'b1, !idle_low);
		end_test();

		begin_test("framing_error");
		build_short_program();
		load_and_run(1'b1);
		check_flag("lost", 1'b1, debug.lost);
		check_flag("loaded", 1'b1, debug.loaded);
		end_test();

		begin_test("tx_backpressure");
		build_burst();
		load_and_run(1'b0);
		end_test();

		begin_test("random_after_reset");
		build_random_program();
		load_and_run(1'b0);
		check_flag("lost", 1'b0, debug.lost);
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			errors);
		if (tests_failed == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
source/chip_pkg.sv
source/sync_fifo.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/word_memory.sv
source/program_loader.sv
source/accumulator_core.sv
source/chip.sv
verification/chip_tb.sv
